// ==== include/arb_defines.svh ====
// ----------------------------------------------------------
// arbiter sizing
// requester count and grant index width for the two-chain
// kill arbiter
// ----------------------------------------------------------

`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// number of requesters sharing the resource
// both kill chains and the merger are built this wide
`define ARB_NUM_REQS 8

// width of an encoded grant index
// must cover ARB_NUM_REQS-1
`define ARB_ID_W 3

`endif

// ==== source/arb_cfg_pkg.sv ====
// ----------------------------------------------------------
// arbiter configuration package
// policy opcode selecting how urgent marks are treated
// ----------------------------------------------------------

`default_nettype none

package arb_cfg_pkg;

  // arbitration policy
  // urgent-first runs the fixed chain ahead of round robin
  // flat drops urgent marks, leaving plain round robin
  typedef enum logic {
    pol_urgent_first = 1'b0,
    pol_flat         = 1'b1
  } arb_policy_e;

endpackage

`default_nettype wire

// ==== source/arb_grant_pkg.sv ====
// ----------------------------------------------------------
// grant result package
// source of a registered grant and the merger lock states
// ----------------------------------------------------------

`default_nettype none

package arb_grant_pkg;

  // which chain produced the registered grant
  typedef enum logic [1:0] {
    src_none   = 2'd0,
    src_urgent = 2'd1,
    src_normal = 2'd2
  } grant_src_e;

  // merger state
  // open lets the chains arbitrate every cycle
  // locked keeps the current holder and kills both chains
  typedef enum logic {
    ms_open   = 1'b0,
    ms_locked = 1'b1
  } merge_state_e;

endpackage

`default_nettype wire

// ==== source/urgent_fixed_arb.sv ====
// ----------------------------------------------------------
// urgent fixed-priority chain
// lowest pending urgent index wins, kill passed on to the
// round-robin chain
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "arb_defines.svh"

module urgent_fixed_arb
  import arb_cfg_pkg::*;
(
  input  logic                     kin,
  input  logic [`ARB_NUM_REQS-1:0] urgent,
  input  logic [`ARB_NUM_REQS-1:0] req,
  input  arb_policy_e              policy,
  output logic [`ARB_NUM_REQS-1:0] grants,
  output logic                     kout
);

  localparam int N = `ARB_NUM_REQS;

  // urgent marks only count on a pending request
  // flat policy removes the whole urgent class
  logic [N-1:0] urgent_req;

  // kills[i] is high once a higher priority index has won
  logic [N:0]   kills;
  logic [N-1:0] grants_int;

  assign urgent_req = (policy == pol_flat) ? '0 : (urgent & req);

  // nothing above requester 0
  assign kills[0] = 1'b0;

  genvar i;
  generate
    for (i = 0; i < N; i++) begin : g_chain
      // win if pending and nobody above has won
      assign grants_int[i] = !kills[i] && urgent_req[i];
      // pass the kill down once anyone at or above has won
      assign kills[i+1]    = kills[i] || grants_int[i];
    end
  endgenerate

  // kin is applied after the chain so it is off the ripple path
  assign grants = grants_int & {N{~kin}};

  // downstream chain is killed by our own win or by our kin
  assign kout = kills[N] || kin;

endmodule

`default_nettype wire

// ==== source/normal_rr_arb.sv ====
// ----------------------------------------------------------
// round-robin chain
// variable priority kill chain unrolled twice, with a one-hot
// priority register that rotates past each winner
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "arb_defines.svh"

module normal_rr_arb (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     kin,
  input  logic [`ARB_NUM_REQS-1:0] req,
  output logic [`ARB_NUM_REQS-1:0] grants
);

  localparam int N = `ARB_NUM_REQS;

  // one-hot, the set bit marks the highest priority requester
  logic [N-1:0]   prio;
  logic [N-1:0]   prio_next;
  logic           prio_en;

  // chain unrolled twice so the wrap around needs no loop
  logic [2*N-1:0] prio_int;
  logic [2*N-1:0] req_int;
  logic [2*N-1:0] grants_int;
  logic [2*N-1:0] kills;

  // ----------------------------------------------------------
  // replicated kill chain
  // ----------------------------------------------------------

  // priority only marks the lower copy, the upper copy catches
  // the requesters below the priority index after the wrap
  assign prio_int = {{N{1'b0}}, prio};
  assign req_int  = {req, req};

  // entry kill set, so nothing before the priority slot can win
  assign kills[0] = 1'b1;

  genvar i;
  generate
    for (i = 0; i < 2*N; i++) begin : g_chain
      // the priority slot ignores the incoming kill
      assign grants_int[i] = prio_int[i] ? req_int[i] : (!kills[i] && req_int[i]);
      // last slot has no successor
      if (i < 2*N-1) begin : g_kill
        assign kills[i+1] = prio_int[i] ? grants_int[i] : (kills[i] || grants_int[i]);
      end
    end
  endgenerate

  // fold both copies together, then apply the kill from the urgent side
  assign grants = (grants_int[N-1:0] | grants_int[2*N-1:N]) & {N{~kin}};

  // ----------------------------------------------------------
  // priority register
  // ----------------------------------------------------------

  // advance only on our own grant, a kill leaves grants at zero
  assign prio_en   = |grants;

  // winner rotated left by one becomes the new top priority
  assign prio_next = {grants[N-2:0], grants[N-1]};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      // requester 0 first out of reset
      prio <= N'(1);
    end else if (prio_en) begin
      prio <= prio_next;
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // rotation must never lose or duplicate the priority token
  a_prio_onehot : assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot(prio)
  ) else $error("normal_rr_arb: priority register not one-hot");

  // both chain copies must never win at the same time
  a_grants_onehot0 : assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0(grants)
  ) else $error("normal_rr_arb: more than one grant");

endmodule

`default_nettype wire

// ==== source/grant_merge.sv ====
// ----------------------------------------------------------
// grant merger
// merges urgent and normal grants, registers the winner and
// runs the bus lock that freezes both chains
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "arb_defines.svh"

module grant_merge
  import arb_grant_pkg::*;
(
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [`ARB_NUM_REQS-1:0] urgent_grants,
  input  logic [`ARB_NUM_REQS-1:0] normal_grants,
  input  logic [`ARB_NUM_REQS-1:0] req,
  input  logic                     lock,
  output logic                     hold,
  output logic                     grant_valid,
  output logic [`ARB_NUM_REQS-1:0] grant,
  output logic [`ARB_ID_W-1:0]     grant_id,
  output grant_src_e               grant_src
);

  localparam int N = `ARB_NUM_REQS;

  merge_state_e           state;
  logic [N-1:0]           merged;
  logic [`ARB_ID_W-1:0]   merged_id;
  grant_src_e             merged_src;
  logic                   holder_keep;

  // ----------------------------------------------------------
  // merge and encode
  // ----------------------------------------------------------

  // kill chaining keeps the two vectors exclusive, a plain OR is enough
  assign merged = urgent_grants | normal_grants;

  // one-hot to index
  always_comb begin
    merged_id = '0;
    for (int i = 0; i < N; i++) begin
      if (merged[i]) begin
        merged_id = i[`ARB_ID_W-1:0];
      end
    end
  end

  // tag the winning chain
  always_comb begin
    if (|urgent_grants) begin
      merged_src = src_urgent;
    end else if (|normal_grants) begin
      merged_src = src_normal;
    end else begin
      merged_src = src_none;
    end
  end

  // ----------------------------------------------------------
  // lock state and grant registers
  // ----------------------------------------------------------

  // holder stays as long as its own request and the lock are both up
  assign holder_keep = lock && |(grant & req);

  // registered, so the kill path back into the chains has no loop
  assign hold = (state == ms_locked);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= ms_open;
      grant_valid <= 1'b0;
      grant       <= '0;
      grant_id    <= '0;
      grant_src   <= src_none;
    end else begin
      case (state)
        ms_open: begin
          // take whatever the chains produced this cycle
          grant_valid <= |merged;
          grant       <= merged;
          grant_id    <= merged_id;
          grant_src   <= merged_src;
          // lock seen together with a new grant
          if ((|merged) && lock) begin
            state <= ms_locked;
          end
        end
        ms_locked: begin
          // chains are killed here, so only the holder matters
          // release leaves one empty cycle before arbitration resumes
          if (!holder_keep) begin
            state       <= ms_open;
            grant_valid <= 1'b0;
            grant       <= '0;
            grant_id    <= '0;
            grant_src   <= src_none;
          end
        end
        default: begin
          state <= ms_open;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // urgent kout must have killed the round-robin chain
  a_grants_exclusive : assert property (
    @(posedge clk) disable iff (!rstn)
    !((|urgent_grants) && (|normal_grants))
  ) else $error("grant_merge: urgent and normal grant in one cycle");

  a_grant_onehot : assert property (
    @(posedge clk) disable iff (!rstn)
    grant_valid |-> $onehot(grant)
  ) else $error("grant_merge: valid grant not one-hot");

endmodule

`default_nettype wire

// ==== source/arb_top.sv ====
// ----------------------------------------------------------
// shared resource arbiter top
// urgent fixed chain ripples its kill into the round-robin
// chain, the merger registers the winner and holds locks
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "arb_defines.svh"

module arb_top
  import arb_cfg_pkg::*;
  import arb_grant_pkg::*;
(
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [`ARB_NUM_REQS-1:0] req,
  input  logic [`ARB_NUM_REQS-1:0] urgent,
  input  logic                     lock,
  input  arb_policy_e              policy,
  output logic                     grant_valid,
  output logic [`ARB_NUM_REQS-1:0] grant,
  output logic [`ARB_ID_W-1:0]     grant_id,
  output grant_src_e               grant_src
);

  logic [`ARB_NUM_REQS-1:0] urgent_grants;
  logic [`ARB_NUM_REQS-1:0] normal_grants;
  // urgent win or lock hold, kills the round-robin chain
  logic                     urgent_kout;
  // lock hold from the merger, head of the kill ripple
  logic                     hold;

  urgent_fixed_arb u_urgent (
    .kin    (hold),
    .urgent (urgent),
    .req    (req),
    .policy (policy),
    .grants (urgent_grants),
    .kout   (urgent_kout)
  );

  normal_rr_arb u_normal (
    .clk    (clk),
    .rstn   (rstn),
    .kin    (urgent_kout),
    .req    (req),
    .grants (normal_grants)
  );

  grant_merge u_merge (
    .clk           (clk),
    .rstn          (rstn),
    .urgent_grants (urgent_grants),
    .normal_grants (normal_grants),
    .req           (req),
    .lock          (lock),
    .hold          (hold),
    .grant_valid   (grant_valid),
    .grant         (grant),
    .grant_id      (grant_id),
    .grant_src     (grant_src)
  );

endmodule

`default_nettype wire

// ==== dv/arb_tb.sv ====
// ----------------------------------------------------------
// arbiter testbench
// directed urgent, round-robin, flat and lock tests, then a
// random mix checked against a cycle model of the arbiter
// ----------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "arb_defines.svh"

module arb_tb
  import arb_cfg_pkg::*;
  import arb_grant_pkg::*;
();

  localparam int N = `ARB_NUM_REQS;
  // reset 10, directed tests about 60, random 400, plus margin
  localparam int MAX_CYCLES = 700;

  // expected winner of one arbitration
  typedef struct packed {
    grant_src_e           src;
    logic [`ARB_ID_W-1:0] id;
    logic [N-1:0]         grant;
  } win_t;

  logic                 clk;
  logic                 rstn;
  logic [N-1:0]         req;
  logic [N-1:0]         urgent;
  logic                 lock;
  arb_policy_e          policy;
  logic                 grant_valid;
  logic [N-1:0]         grant;
  logic [`ARB_ID_W-1:0] grant_id;
  grant_src_e           grant_src;

  // model state
  int                   m_ptr;
  merge_state_e         m_state;
  logic                 m_valid;
  logic [N-1:0]         m_grant;
  logic [`ARB_ID_W-1:0] m_id;
  grant_src_e           m_src;
  win_t                 nxt;

  integer               seed;
  int                   cycle_count;
  int                   check_count;
  int                   error_count;
  int                   test_errors;
  logic                 check_en;
  int                   seen [N];
  logic [`ARB_ID_W-1:0] holder;

  arb_top u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .req         (req),
    .urgent      (urgent),
    .lock        (lock),
    .policy      (policy),
    .grant_valid (grant_valid),
    .grant       (grant),
    .grant_id    (grant_id),
    .grant_src   (grant_src)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  // urgent class first by lowest index, else round robin from ptr
  // a held lock blocks both classes
  function automatic win_t predict_winner(input logic [N-1:0] r, input logic [N-1:0] u,
                                          input arb_policy_e pol, input int ptr,
                                          input logic held);
    win_t w;
    int   idx;
    w.src   = src_none;
    w.id    = '0;
    w.grant = '0;
    if (!held) begin
      if (pol == pol_urgent_first) begin
        for (int i = 0; i < N; i++) begin
          if (r[i] && u[i] && w.src == src_none) begin
            w.src      = src_urgent;
            w.id       = i[`ARB_ID_W-1:0];
            w.grant[i] = 1'b1;
          end
        end
      end
      for (int k = 0; k < N; k++) begin
        idx = (ptr + k) % N;
        if (r[idx] && w.src == src_none) begin
          w.src        = src_normal;
          w.id         = idx[`ARB_ID_W-1:0];
          w.grant[idx] = 1'b1;
        end
      end
    end
    return w;
  endfunction

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m_ptr   <= 0;
      m_state <= ms_open;
      m_valid <= 1'b0;
      m_grant <= '0;
      m_id    <= '0;
      m_src   <= src_none;
    end else begin
      nxt = predict_winner(req, urgent, policy, m_ptr, m_state == ms_locked);
      // pointer moves only past a round-robin winner
      if (nxt.src == src_normal) begin
        m_ptr <= (nxt.id + 1) % N;
      end
      if (m_state == ms_open) begin
        m_valid <= |nxt.grant;
        m_grant <= nxt.grant;
        m_id    <= nxt.id;
        m_src   <= nxt.src;
        if ((|nxt.grant) && lock) begin
          m_state <= ms_locked;
        end
      end else if (!(lock && |(m_grant & req))) begin
        // release cycle shows no grant
        m_state <= ms_open;
        m_valid <= 1'b0;
        m_grant <= '0;
        m_id    <= '0;
        m_src   <= src_none;
      end
    end
  end

  // ----------------------------------------------------------
  // checking
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rstn && check_en) begin
      check_value("grant_valid", m_valid, grant_valid);
      check_value("grant", m_grant, grant);
      check_value("grant_id", m_id, grant_id);
      check_value("grant_src", m_src, grant_src);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  task automatic drive_inputs(input logic [N-1:0] r, input logic [N-1:0] u, input logic l,
                              input arb_policy_e p);
    @(posedge clk);
    #5;
    req    = r;
    urgent = u;
    lock   = l;
    policy = p;
  endtask

  // one sampling edge, then the stable point after it
  task automatic next_result();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic report_test(input string name);
    $display("test %s done with %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------

  initial begin
    clk         = 1'b0;
    rstn        = 1'b0;
    req         = '0;
    urgent      = '0;
    lock        = 1'b0;
    policy      = pol_urgent_first;
    seed        = 25079;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    test_errors = 0;
    check_en    = 1'b0;
    repeat (10) @(posedge clk);
    #5;
    rstn     = 1'b1;
    check_en = 1'b1;

    // idle after reset
    drive_inputs('0, '0, 1'b0, pol_urgent_first);
    repeat (5) begin
      next_result();
      check_value("grant_valid", 1'b0, grant_valid);
      check_value("grant_src", src_none, grant_src);
    end
    report_test("reset state");

    // lowest urgent index beats every normal request
    drive_inputs(8'hff, 8'b0110_1000, 1'b0, pol_urgent_first);
    next_result();
    check_value("grant_id", 3, grant_id);
    check_value("grant_src", src_urgent, grant_src);
    drive_inputs(8'hff, 8'b1000_0000, 1'b0, pol_urgent_first);
    next_result();
    check_value("grant_id", 7, grant_id);
    check_value("grant_src", src_urgent, grant_src);
    report_test("urgent priority");

    // pointer still at 0 since urgent wins never move it
    for (int i = 0; i < N; i++) begin
      seen[i] = 0;
    end
    drive_inputs(8'hff, '0, 1'b0, pol_urgent_first);
    for (int k = 0; k < 2*N; k++) begin
      next_result();
      check_value("grant_id", k % N, grant_id);
      check_value("grant_src", src_normal, grant_src);
      seen[grant_id]++;
    end
    for (int i = 0; i < N; i++) begin
      check_value("grant count", 2, seen[i]);
    end
    report_test("round robin");

    // all marked urgent but flat policy ignores it
    drive_inputs(8'b1010_0110, 8'hff, 1'b0, pol_flat);
    repeat (12) begin
      next_result();
      check_value("grant_src", src_normal, grant_src);
    end
    report_test("flat policy");

    // lock whoever wins next, hold it, then release
    drive_inputs(8'hff, '0, 1'b1, pol_urgent_first);
    @(posedge clk);
    do begin
      @(negedge clk);
    end while (!grant_valid);
    holder = grant_id;
    repeat (5) begin
      @(negedge clk);
      check_value("grant_valid", 1'b1, grant_valid);
      check_value("grant_id", holder, grant_id);
    end
    drive_inputs(8'hff, '0, 1'b0, pol_urgent_first);
    next_result();
    check_value("grant_valid", 1'b0, grant_valid);
    @(negedge clk);
    // frozen pointer resumes right after the holder
    check_value("grant_id", (holder + 1) % N, grant_id);
    report_test("lock");

    // random mix checked every cycle by the model compare
    repeat (400) begin
      drive_inputs(N'($random(seed)), N'($random(seed) & $random(seed)),
                   ($random(seed) & 3) == 0, arb_policy_e'($random(seed) & 1));
    end
    next_result();
    report_test("random mix");

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
source/arb_cfg_pkg.sv
source/arb_grant_pkg.sv
source/urgent_fixed_arb.sv
source/normal_rr_arb.sv
source/grant_merge.sv
source/arb_top.sv
dv/arb_tb.sv

// ==== Bender.yml ====
package:
  name: arb_kill_chain

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/arb_cfg_pkg.sv
      - source/arb_grant_pkg.sv
      - source/urgent_fixed_arb.sv
      - source/normal_rr_arb.sv
      - source/grant_merge.sv
      - source/arb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/arb_tb.sv
